/* vlog.f */
+incdir+.
ufm_pkg.sv
ufm_cmd_decode.sv
ufm_page_sequencer.sv
ufm_page_store.sv
ufm_read_assemble.sv
ufm_page_ctrl.sv
tb_clock_gen.sv
tb_ufm_page_ctrl.sv

/* Bender.yml */
package:
  name: ufm_page_ctrl

export_include_dirs:
  - .

sources:
  - ufm_pkg.sv
  - ufm_cmd_decode.sv
  - ufm_page_sequencer.sv
  - ufm_page_store.sv
  - ufm_read_assemble.sv
  - ufm_page_ctrl.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_ufm_page_ctrl.sv

/* tb_ufm_page_ctrl.sv */
`include "ufm_settings.svh"

module tb_ufm_page_ctrl;

    timeunit 1ns;
    timeprecision 100ps;

    // Commands over all tests and the cycle budget of each
    localparam int NUM_CMDS     = 55;
    localparam int CMD_CYCLES   = `UFM_ERASE_CYCLES + 4 * `UFM_PROG_CYCLES + 32;
    localparam int TIMEOUT_NS   = NUM_CMDS * CMD_CYCLES * 40;
    localparam int RANDOM_OPS   = 40;

    logic        WrStrb_sync;
    logic        rst_n;
    logic        cmd_valid;
    logic        cmd_write;
    logic [`UFM_PAGE_ADDR_W-1:0] cmd_page;
    logic [31:0] cmd_data;
    logic        cmd_ready;
    logic        rsp_valid;
    logic        rsp_ready;
    logic [31:0] rsp_data;

    // Shadow flash and outstanding read results
    logic [31:0] shadow [`UFM_PAGE_COUNT];
    logic        written [`UFM_PAGE_COUNT];
    logic [31:0] exp_q [$];
    logic [31:0] lcg_state;
    logic [31:0] held_word;
    logic [31:0] rnd;
    logic [31:0] exp_word;
    int          errors;
    int          checks;
    int          test_errors;

    tb_clock_gen u_clock (.WrStrb_sync(WrStrb_sync), .rst_n(rst_n));

    ufm_page_ctrl DUT (.*);

    // ----------------------------------------------------------------------
    // Reference model and random source
    // ----------------------------------------------------------------------

    // Erase sets all ones and program clears bits
    function automatic void model_write(input logic [`UFM_PAGE_ADDR_W-1:0] page,
                                        input logic [31:0] data);
        shadow[page] = {`UFM_WORD_BYTES{`UFM_ERASED_BYTE}};
        shadow[page] = shadow[page] & data;
        written[page] = 1'b1;
    endfunction

    function automatic logic [31:0] model_read(input logic [`UFM_PAGE_ADDR_W-1:0] page);
        return shadow[page];
    endfunction

    // Numerical Recipes constants
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ----------------------------------------------------------------------
    // Stimulus helpers enter and leave on a falling edge
    // ----------------------------------------------------------------------
    task automatic issue_cmd(input logic wr, input logic [`UFM_PAGE_ADDR_W-1:0] page,
                             input logic [31:0] data);
        // Expected value fixed at issue since commands run in order
        if (wr) begin
            model_write(page, data);
        end else begin
            exp_q.push_back(model_read(page));
        end
        cmd_valid = 1'b1;
        cmd_write = wr;
        cmd_page  = page;
        cmd_data  = data;
        while (!cmd_ready) @(negedge WrStrb_sync);
        // Transfer on the rising edge in between
        @(negedge WrStrb_sync);
        cmd_valid = 1'b0;
    endtask

    task automatic end_test(input int num, input string name);
        while (exp_q.size() != 0) @(negedge WrStrb_sync);
        $display("test %0d %s finished with %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    // ----------------------------------------------------------------------
    // Responses checked in order against the expected queue
    // ----------------------------------------------------------------------
    always @(posedge WrStrb_sync) begin
        if (rst_n && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                $display("Response arrived with no read outstanding");
                errors++;
            end else begin
                exp_word = exp_q.pop_front();
                checks++;
                if (rsp_data !== exp_word) begin
                    $display("Mismatch rsp_data: got %08h expected %08h", rsp_data, exp_word);
                    errors++;
                end
            end
        end
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the DUT stopped making progress", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        cmd_valid   = 1'b0;
        cmd_write   = 1'b0;
        cmd_page    = '0;
        cmd_data    = '0;
        rsp_ready   = 1'b1;
        lcg_state   = 32'd78;
        errors      = 0;
        checks      = 0;
        test_errors = 0;
        for (int p = 0; p < `UFM_PAGE_COUNT; p++) begin
            written[p] = 1'b0;
        end
        wait (rst_n);
        @(negedge WrStrb_sync);

        // Idle state out of reset
        if (cmd_ready !== 1'b1) begin
            $display("Mismatch cmd_ready: got %h expected 1", cmd_ready);
            errors++;
        end
        if (rsp_valid !== 1'b0) begin
            $display("Mismatch rsp_valid: got %h expected 0", rsp_valid);
            errors++;
        end
        end_test(1, "reset state");

        issue_cmd(1'b1, 2'd1, 32'hA5C3_1E77);
        issue_cmd(1'b0, 2'd1, '0);
        end_test(2, "write then read");

        // Second word sets bits the first cleared so erase must run
        issue_cmd(1'b1, 2'd2, 32'h0F0F_F0F0);
        issue_cmd(1'b1, 2'd2, 32'hF0F0_0F0F);
        issue_cmd(1'b0, 2'd2, '0);
        end_test(3, "overwrite erases page");

        for (int p = 0; p < `UFM_PAGE_COUNT; p++) begin
            issue_cmd(1'b1, `UFM_PAGE_ADDR_W'(p), 32'h1000_0001 * (p + 3));
        end
        for (int p = 0; p < `UFM_PAGE_COUNT; p++) begin
            issue_cmd(1'b0, `UFM_PAGE_ADDR_W'(p), '0);
        end
        end_test(4, "all pages separate");

        // Host stalls and the second read stays in the holding slot
        rsp_ready = 1'b0;
        issue_cmd(1'b0, 2'd0, '0);
        issue_cmd(1'b0, 2'd3, '0);
        while (!rsp_valid) @(negedge WrStrb_sync);
        held_word = rsp_data;
        repeat (12) begin
            @(negedge WrStrb_sync);
            if (!rsp_valid) begin
                $display("rsp_valid dropped while rsp_ready was held low");
                errors++;
            end
            if (rsp_data !== held_word) begin
                $display("Mismatch rsp_data: got %08h expected %08h", rsp_data, held_word);
                errors++;
            end
        end
        if (cmd_ready !== 1'b0) begin
            $display("Mismatch cmd_ready: got %h expected 0", cmd_ready);
            errors++;
        end
        rsp_ready = 1'b1;
        end_test(5, "response back-pressure");

        // Random mix where unwritten pages get a write instead of a read
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rnd = lcg_next();
            if (rnd[31] || !written[rnd[17:16]]) begin
                issue_cmd(1'b1, rnd[17:16], lcg_next());
            end else begin
                issue_cmd(1'b0, rnd[17:16], '0);
            end
        end
        end_test(6, "random mix");

        $display("%0d responses checked, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic WrStrb_sync,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD_NS = 20;

    // Free running clock, 40 ns period
    initial begin
        WrStrb_sync = 1'b0;
        forever #(HALF_PERIOD_NS) WrStrb_sync = ~WrStrb_sync;
    end

    // Reset held for two rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge WrStrb_sync);
        @(negedge WrStrb_sync);
        rst_n = 1'b1;
    end

endmodule

/* ufm_page_ctrl.sv */
`include "ufm_settings.svh"

module ufm_page_ctrl import ufm_pkg::*; (
    input  logic                        WrStrb_sync,
    input  logic                        rst_n,
    input  logic                        cmd_valid,
    input  logic                        cmd_write,
    input  logic [`UFM_PAGE_ADDR_W-1:0] cmd_page,
    input  logic [31:0]                 cmd_data,
    output logic                        cmd_ready,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output logic [31:0]                 rsp_data
);

    localparam int IDX_W = $clog2(`UFM_WORD_BYTES);

    // ----------------------------------------------------------------------
    // Decode to sequencer
    // ----------------------------------------------------------------------
    logic                        job_valid;
    logic                        job_ready;
    ufm_job_e                    job_kind;
    logic [`UFM_PAGE_ADDR_W-1:0] job_page;
    ufm_word_u                   job_word;

    // Sequencer to store
    logic                        op_start;
    ufm_store_op_e               op_kind;
    logic [`UFM_PAGE_ADDR_W-1:0] op_page;
    logic [IDX_W-1:0]            op_byte_idx;
    logic [7:0]                  op_wdata;
    logic                        op_done;
    logic [7:0]                  op_rdata;

    // Sequencer to read assembly
    logic                        byte_valid;
    logic [IDX_W-1:0]            byte_idx;
    logic [7:0]                  byte_data;
    logic                        asm_ready;

    ufm_cmd_decode u_decode (.*);

    ufm_page_sequencer u_sequencer (.*);

    // Behavioral flash page array
    ufm_page_store u_store (.*);

    ufm_read_assemble u_assemble (.*);

endmodule

/* ufm_read_assemble.sv */
`include "ufm_settings.svh"

module ufm_read_assemble import ufm_pkg::*; (
    input  logic                                WrStrb_sync,
    input  logic                                rst_n,
    // Byte stream from the sequencer
    input  logic                                byte_valid,
    input  logic [$clog2(`UFM_WORD_BYTES)-1:0]  byte_idx,
    input  logic [7:0]                          byte_data,
    output logic                                asm_ready,
    // Host response
    output logic                                rsp_valid,
    input  logic                                rsp_ready,
    output logic [31:0]                         rsp_data
);

    localparam int IDX_W = $clog2(`UFM_WORD_BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`UFM_WORD_BYTES - 1);

    // Word under construction, then held as the response
    ufm_word_u asm_word;

    assign rsp_data  = asm_word.word;
    // No new read while a word waits for the host
    assign asm_ready = !rsp_valid;

    // ----------------------------------------------------------------------
    // Response valid
    // ----------------------------------------------------------------------
    always_ff @(posedge WrStrb_sync or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (byte_valid && (byte_idx == LAST_IDX)) begin
            // Highest lane completes the word
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // Lane placement by byte index
    always_ff @(posedge WrStrb_sync) begin
        if (byte_valid) begin
            asm_word.bytes[byte_idx] <= byte_data;
        end
    end

endmodule

/* ufm_page_store.sv */
`include "ufm_settings.svh"

module ufm_page_store import ufm_pkg::*; (
    input  logic                                WrStrb_sync,
    input  logic                                rst_n,
    input  logic                                op_start,
    input  ufm_store_op_e                       op_kind,
    input  logic [`UFM_PAGE_ADDR_W-1:0]         op_page,
    input  logic [$clog2(`UFM_WORD_BYTES)-1:0]  op_byte_idx,
    input  logic [7:0]                          op_wdata,
    output logic                                op_done,
    output logic [7:0]                          op_rdata
);

    localparam int CNT_W = $clog2(`UFM_ERASE_CYCLES + 1);

    // Page array, one byte per cell
    logic [7:0] mem [`UFM_PAGE_COUNT][`UFM_WORD_BYTES];

    logic                               busy;
    logic [CNT_W-1:0]                   busy_cnt;
    // Operation held while busy
    ufm_store_op_e                      kind_q;
    logic [`UFM_PAGE_ADDR_W-1:0]        page_q;
    logic [$clog2(`UFM_WORD_BYTES)-1:0] idx_q;
    logic [7:0]                         wdata_q;

    // Done on the last busy cycle
    assign op_done  = busy && (busy_cnt == '0);
    // Read data valid alongside op_done
    assign op_rdata = mem[page_q][idx_q];

    // ----------------------------------------------------------------------
    // Busy timer
    // ----------------------------------------------------------------------
    always_ff @(posedge WrStrb_sync or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (op_start && !busy) begin
            busy <= 1'b1;
            case (op_kind)
                ERASE:   busy_cnt <= CNT_W'(`UFM_ERASE_CYCLES - 1);
                PROG:    busy_cnt <= CNT_W'(`UFM_PROG_CYCLES - 1);
                default: busy_cnt <= '0;
            endcase
        end else if (op_done) begin
            busy <= 1'b0;
        end else if (busy) begin
            busy_cnt <= busy_cnt - 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // Array update at the end of the operation
    // ----------------------------------------------------------------------
    always_ff @(posedge WrStrb_sync) begin
        if (op_start && !busy) begin
            kind_q  <= op_kind;
            page_q  <= op_page;
            idx_q   <= op_byte_idx;
            wdata_q <= op_wdata;
        end
        if (op_done && (kind_q == ERASE)) begin
            for (int b = 0; b < `UFM_WORD_BYTES; b++) begin
                mem[page_q][b] <= `UFM_ERASED_BYTE;
            end
        end else if (op_done && (kind_q == PROG)) begin
            // Programming only clears bits
            mem[page_q][idx_q] <= mem[page_q][idx_q] & wdata_q;
        end
    end

endmodule

/* ufm_page_sequencer.sv */
`include "ufm_settings.svh"

module ufm_page_sequencer import ufm_pkg::*; (
    input  logic                                WrStrb_sync,
    input  logic                                rst_n,
    // Job from decode
    input  logic                                job_valid,
    output logic                                job_ready,
    input  ufm_job_e                            job_kind,
    input  logic [`UFM_PAGE_ADDR_W-1:0]         job_page,
    input  ufm_word_u                           job_word,
    // Store operation port
    output logic                                op_start,
    output ufm_store_op_e                       op_kind,
    output logic [`UFM_PAGE_ADDR_W-1:0]         op_page,
    output logic [$clog2(`UFM_WORD_BYTES)-1:0]  op_byte_idx,
    output logic [7:0]                          op_wdata,
    input  logic                                op_done,
    input  logic [7:0]                          op_rdata,
    // Read bytes to the assembler
    output logic                                byte_valid,
    output logic [$clog2(`UFM_WORD_BYTES)-1:0]  byte_idx,
    output logic [7:0]                          byte_data,
    input  logic                                asm_ready
);

    localparam int IDX_W = $clog2(`UFM_WORD_BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`UFM_WORD_BYTES - 1);

    // FSM encoding
    localparam logic [1:0] ST_STANDBY = 2'd0;
    localparam logic [1:0] ST_ERASE   = 2'd1;
    localparam logic [1:0] ST_PROG    = 2'd2;
    localparam logic [1:0] ST_READ    = 2'd3;

    logic [1:0]       state;
    logic [1:0]       state_nx;
    logic [IDX_W-1:0] byte_cnt;
    logic [IDX_W-1:0] next_idx;
    // Next store operation to launch
    logic             issue;
    ufm_store_op_e    issue_kind;
    logic [IDX_W-1:0] issue_idx;
    logic             job_take;
    // Word being programmed
    ufm_word_u        word_q;

    // Reads only start when the assembler has room for a new word
    assign job_ready = (state == ST_STANDBY) && ((job_kind == ERASE_PROGRAM) || asm_ready);
    assign job_take  = job_valid && job_ready;
    assign next_idx  = byte_cnt + 1'b1;

    // The counter doubles as the store byte address
    assign op_byte_idx = byte_cnt;

    // Read bytes pass straight through with their lane
    assign byte_valid = (state == ST_READ) && op_done;
    assign byte_idx   = byte_cnt;
    assign byte_data  = op_rdata;

    // ----------------------------------------------------------------------
    // Next step decision
    // ----------------------------------------------------------------------
    always_comb begin
        state_nx   = state;
        issue      = 1'b0;
        issue_kind = RDB;
        issue_idx  = next_idx;
        case (state)
            ST_STANDBY: begin
                if (job_take) begin
                    issue     = 1'b1;
                    issue_idx = '0;
                    if (job_kind == ERASE_PROGRAM) begin
                        issue_kind = ERASE;
                        state_nx   = ST_ERASE;
                    end else begin
                        state_nx = ST_READ;
                    end
                end
            end
            ST_ERASE: begin
                // Page blank, program lane 0 next
                if (op_done) begin
                    issue      = 1'b1;
                    issue_kind = PROG;
                    issue_idx  = '0;
                    state_nx   = ST_PROG;
                end
            end
            ST_PROG: begin
                if (op_done) begin
                    if (byte_cnt == LAST_IDX) begin
                        state_nx = ST_STANDBY;
                    end else begin
                        issue      = 1'b1;
                        issue_kind = PROG;
                    end
                end
            end
            default: begin
                // Read, one byte per store operation
                if (op_done) begin
                    if (byte_cnt == LAST_IDX) begin
                        state_nx = ST_STANDBY;
                    end else begin
                        issue = 1'b1;
                    end
                end
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // Control registers
    // ----------------------------------------------------------------------
    always_ff @(posedge WrStrb_sync or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_STANDBY;
            op_start <= 1'b0;
            byte_cnt <= '0;
        end else begin
            state    <= state_nx;
            // Single cycle start pulse
            op_start <= issue;
            if (issue) begin
                byte_cnt <= issue_idx;
            end
        end
    end

    // Operation payload and job capture
    always_ff @(posedge WrStrb_sync) begin
        if (job_take) begin
            op_page <= job_page;
            word_q  <= job_word;
        end
        if (issue) begin
            op_kind  <= issue_kind;
            op_wdata <= word_q.bytes[issue_idx];
        end
    end

endmodule

/* ufm_cmd_decode.sv */
`include "ufm_settings.svh"

module ufm_cmd_decode import ufm_pkg::*; (
    input  logic                        WrStrb_sync,
    input  logic                        rst_n,
    // Host command side
    input  logic                        cmd_valid,
    input  logic                        cmd_write,
    input  logic [`UFM_PAGE_ADDR_W-1:0] cmd_page,
    input  logic [31:0]                 cmd_data,
    output logic                        cmd_ready,
    // Job to the sequencer
    output logic                        job_valid,
    input  logic                        job_ready,
    output ufm_job_e                    job_kind,
    output logic [`UFM_PAGE_ADDR_W-1:0] job_page,
    output ufm_word_u                   job_word
);

    // One entry holding slot
    logic slot_full;
    logic cmd_take;
    logic job_take;

    // Handshakes on both sides
    assign cmd_take = cmd_valid && cmd_ready;
    assign job_take = job_valid && job_ready;

    // Slot accepts only while empty
    assign cmd_ready = !slot_full;
    assign job_valid = slot_full;

    // ----------------------------------------------------------------------
    // Slot occupancy
    // ----------------------------------------------------------------------
    always_ff @(posedge WrStrb_sync or negedge rst_n) begin
        if (!rst_n) begin
            slot_full <= 1'b0;
        end else if (cmd_take) begin
            slot_full <= 1'b1;
        end else if (job_take) begin
            // Freed once the sequencer picks the job up
            slot_full <= 1'b0;
        end
    end

    // ----------------------------------------------------------------------
    // Slot contents
    // ----------------------------------------------------------------------
    always_ff @(posedge WrStrb_sync) begin
        if (cmd_take) begin
            // Write means erase then program, anything else is a read
            job_kind      <= cmd_write ? ERASE_PROGRAM : READ;
            job_page      <= cmd_page;
            // Word is only meaningful for writes
            job_word.word <= cmd_data;
        end
    end

endmodule

/* ufm_pkg.sv */
`include "ufm_settings.svh"

package ufm_pkg;

    // Host level job kinds
    typedef enum logic {
        ERASE_PROGRAM,
        READ
    } ufm_job_e;

    // Single store operations, one byte or one page each
    typedef enum logic [1:0] {
        ERASE,
        PROG,
        RDB
    } ufm_store_op_e;

    // One flash word, seen whole or by byte lane
    // Lane 0 is the least significant byte
    typedef union packed {
        logic [8*`UFM_WORD_BYTES-1:0]    word;
        logic [`UFM_WORD_BYTES-1:0][7:0] bytes;
    } ufm_word_u;

endpackage

/* ufm_settings.svh */
`ifndef UFM_SETTINGS_SVH
`define UFM_SETTINGS_SVH

// ----------------------------------------------------------------------
// Page store geometry
// ----------------------------------------------------------------------

// Pages in the store
`define UFM_PAGE_COUNT   4
// Page address bits, log2 of the page count
`define UFM_PAGE_ADDR_W  2
// Bytes per stored word, lsb first
`define UFM_WORD_BYTES   4

// ----------------------------------------------------------------------
// Store busy timing, in clock cycles
// ----------------------------------------------------------------------

// Whole page erase
`define UFM_ERASE_CYCLES 64
// One byte program
`define UFM_PROG_CYCLES  4
// Erased flash reads back as all ones
`define UFM_ERASED_BYTE  8'hFF

`endif
